// File: eth_credit_link.sv
`timescale 1ns/1ps
`default_nettype none

module eth_credit_link #(
    parameter int unsigned LINK_DEPTH = 8
) (
    input  wire                      i_eth_clk,
    input  wire                      resetn,
    input  wire                      i_valid,
    input  eth_loop_pkg::eth_data_t  i_data,
    input  wire                      i_sop,
    input  wire                      i_eop,
    input  eth_loop_pkg::eth_addr_t  i_addr,
    input  wire                      i_ready,
    output logic                     o_valid,
    output eth_loop_pkg::eth_data_t  o_data,
    output logic                     o_sop,
    output logic                     o_eop,
    output eth_loop_pkg::eth_addr_t  o_addr,
    output logic                     o_credit
);

    localparam int unsigned AW = (LINK_DEPTH > 1) ? $clog2(LINK_DEPTH) : 1;
    localparam int unsigned CW = $clog2(LINK_DEPTH + 1);
    localparam int unsigned EW = $bits(eth_loop_pkg::eth_data_t) + 6;

    // Each entry holds the word with sop, eop and address below it
    logic [EW-1:0] mem [LINK_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop;

    assign pop = o_valid && i_ready;

    // Every valid cycle writes the entry at the write pointer
    always_ff @(posedge i_eth_clk) begin
        if (i_valid) begin
            mem[wr_ptr] <= {i_data, i_sop, i_eop, i_addr};
        end
    end

    always_ff @(posedge i_eth_clk) begin
        if (!resetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_valid) begin
                wr_ptr <= (wr_ptr == AW'(LINK_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(LINK_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count + CW'(i_valid) - CW'(pop);
            // One credit back to the sender in the cycle after each pop
            o_credit <= pop;
        end
    end

    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr][EW-1:6];
    assign o_sop   = mem[rd_ptr][5];
    assign o_eop   = mem[rd_ptr][4];
    assign o_addr  = mem[rd_ptr][3:0];

    // Sender credit accounting must keep writes away from a full buffer
    a_no_overflow: assert property (@(posedge i_eth_clk) disable iff (!resetn)
        !(i_valid && (count == CW'(LINK_DEPTH))));

endmodule

`default_nettype wire

// File: eth_ctrl_capture.sv
`timescale 1ns/1ps
`default_nettype none

module eth_ctrl_capture #(
    parameter int unsigned PIPE_LEN = 3
) (
    input  wire        i_eth_clk,
    input  wire        resetn,
    input  wire        i_stimuli_valid,
    input  wire [1:0]  i_tx_enable,
    input  wire [1:0]  i_tx_id,
    output logic [1:0] o_tx_enable,
    output logic [1:0] o_tx_id
);

    // Enable in the upper two bits, ID in the lower two
    logic [3:0] held;
    logic [3:0] pipe [PIPE_LEN];

    // Control inputs may still be settling, so they are taken only on the strobe
    always_ff @(posedge i_eth_clk) begin
        if (!resetn) begin
            held <= '0;
        end else if (i_stimuli_valid) begin
            held <= {i_tx_enable, i_tx_id};
        end
    end

    // Delivery chain toward the senders at both ends of the die
    // Values reach the outputs PIPE_LEN+1 edges after the strobe
    always_ff @(posedge i_eth_clk) begin
        if (!resetn) begin
            for (int i = 0; i < PIPE_LEN; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= held;
            for (int i = 1; i < PIPE_LEN; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign o_tx_enable = pipe[PIPE_LEN-1][3:2];
    assign o_tx_id     = pipe[PIPE_LEN-1][1:0];

endmodule

`default_nettype wire

// File: eth_frame_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module eth_frame_receiver #(
    parameter eth_loop_pkg::eth_addr_t MY_ADDR = 4'hF
) (
    input  wire                      i_eth_clk,
    input  wire                      resetn,
    input  wire                      i_valid,
    input  eth_loop_pkg::eth_data_t  i_data,
    input  wire                      i_sop,
    input  wire                      i_eop,
    input  eth_loop_pkg::eth_addr_t  i_addr,
    input  wire                      i_stall,
    output logic                     o_ready,
    output eth_loop_pkg::eth_count_t o_frame_count,
    output eth_loop_pkg::eth_led_t   o_led,
    output logic                     o_error
);

    eth_loop_pkg::eth_seq_t last_seq;
    eth_loop_pkg::eth_seq_t word_seq;
    logic                   word_id;
    logic                   in_frame;
    logic                   seq_seen;
    logic                   xfer;

    // Stall input is the only source of back-pressure
    assign o_ready  = !i_stall;
    assign xfer     = i_valid && o_ready;
    assign word_id  = i_data[63];
    assign word_seq = i_data[47:32];

    // ----------------------------------------
    // Framing and sequence checks
    // ----------------------------------------
    always_ff @(posedge i_eth_clk) begin
        if (!resetn) begin
            in_frame <= 1'b0;
            seq_seen <= 1'b0;
            last_seq <= '0;
            o_error  <= 1'b0;
        end else if (xfer) begin
            // Error is sticky until the next reset
            if (in_frame == i_sop) begin
                o_error <= 1'b1;
            end
            if (i_sop) begin
                // First frame after reset sets the reference sequence
                if (seq_seen && (word_seq != last_seq + 1'b1)) begin
                    o_error <= 1'b1;
                end
                last_seq <= word_seq;
                seq_seen <= 1'b1;
            end
            in_frame <= !i_eop;
        end
    end

    // Count and LED update one edge after the final word of a frame for this node
    always_ff @(posedge i_eth_clk) begin
        if (!resetn) begin
            o_frame_count <= '0;
            o_led         <= '0;
        end else if (xfer && i_eop && (i_addr == MY_ADDR)) begin
            o_frame_count <= o_frame_count + 1'b1;
            o_led         <= word_id ? ~word_seq[7:0] : word_seq[7:0];
        end
    end

endmodule

`default_nettype wire

// File: eth_frame_sender.sv
`timescale 1ns/1ps
`default_nettype none

module eth_frame_sender #(
    parameter int unsigned           FRAME_WORDS = 4,
    parameter int unsigned           GAP_CYCLES  = 16,
    parameter int unsigned           LINK_DEPTH  = 8,
    parameter eth_loop_pkg::eth_addr_t DEST_ADDR = 4'hF
) (
    input  wire                      i_eth_clk,
    input  wire                      resetn,
    input  wire                      i_enable,
    input  wire                      i_id,
    input  wire                      i_credit,
    output logic                     o_valid,
    output eth_loop_pkg::eth_data_t  o_data,
    output logic                     o_sop,
    output logic                     o_eop,
    output eth_loop_pkg::eth_addr_t  o_addr
);

    localparam int unsigned CW = $clog2(LINK_DEPTH + 1);

    eth_loop_pkg::sender_state_t state;
    eth_loop_pkg::eth_seq_t      seq;
    logic [7:0]                  word_cnt;
    logic [15:0]                 gap_cnt;
    logic [CW-1:0]               credits;
    logic                        frame_id;

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    always_ff @(posedge i_eth_clk) begin
        if (!resetn) begin
            state    <= eth_loop_pkg::IDLE;
            seq      <= '0;
            word_cnt <= '0;
            gap_cnt  <= '0;
            frame_id <= 1'b0;
        end else begin
            case (state)
                eth_loop_pkg::IDLE: begin
                    if (i_enable) begin
                        state    <= eth_loop_pkg::SEND;
                        word_cnt <= '0;
                        frame_id <= i_id;
                    end
                end
                eth_loop_pkg::SEND: begin
                    // The frame runs to its end even if the enable drops
                    if (o_valid) begin
                        if (word_cnt == 8'(FRAME_WORDS - 1)) begin
                            state   <= eth_loop_pkg::GAP;
                            gap_cnt <= '0;
                            seq     <= seq + 1'b1;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (gap_cnt == 16'(GAP_CYCLES - 1)) begin
                        state    <= i_enable ? eth_loop_pkg::SEND : eth_loop_pkg::IDLE;
                        word_cnt <= '0;
                        frame_id <= i_id;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Credits start at the link depth; one is spent per word, one comes back per pop
    always_ff @(posedge i_eth_clk) begin
        if (!resetn) begin
            credits <= CW'(LINK_DEPTH);
        end else begin
            credits <= credits + CW'(i_credit) - CW'(o_valid);
        end
    end

    // A word goes out in SEND whenever a credit is left
    assign o_valid = (state == eth_loop_pkg::SEND) && (credits != '0);
    assign o_sop   = (state == eth_loop_pkg::SEND) && (word_cnt == 8'd0);
    assign o_eop   = (state == eth_loop_pkg::SEND) && (word_cnt == 8'(FRAME_WORDS - 1));
    assign o_data  = {frame_id, 15'd0, seq, 24'd0, word_cnt};
    assign o_addr  = DEST_ADDR;

    // Link returns no more credits than it was given
    a_credit_bound: assert property (@(posedge i_eth_clk) disable iff (!resetn)
        credits <= CW'(LINK_DEPTH));

endmodule

`default_nettype wire

// File: eth_loop.f
eth_loop_pkg.sv
eth_reset_seq.sv
eth_ctrl_capture.sv
eth_frame_sender.sv
eth_credit_link.sv
eth_frame_receiver.sv
eth_loop_top.sv
eth_loop_tb.sv

// File: eth_loop_pkg.sv
`default_nettype none

package eth_loop_pkg;

    // ----------------------------------------
    // Stream word and field types
    // ----------------------------------------

    // One stream word
    // Bit 63 carries the frame ID, bits 47:32 the sequence number and 7:0 the word index
    typedef logic [63:0] eth_data_t;

    // Destination address carried beside each word
    typedef logic [3:0] eth_addr_t;

    // Received frame counter
    typedef logic [31:0] eth_count_t;

    // Byte shown on the board LEDs
    typedef logic [7:0] eth_led_t;

    // Frame sequence number
    typedef logic [15:0] eth_seq_t;

    // Frame sender FSM states
    typedef enum logic [1:0] {IDLE, SEND, GAP} sender_state_t;

    // ----------------------------------------
    // Defaults handed down by the top level
    // ----------------------------------------
    localparam int unsigned DEF_FRAME_WORDS = 4;
    localparam int unsigned DEF_GAP_CYCLES  = 16;
    localparam int unsigned DEF_LINK_DEPTH  = 8;
    localparam eth_addr_t   DEF_DEST_ADDR   = 4'hF;
    localparam int unsigned DEF_PIPE_LEN    = 3;

endpackage

`default_nettype wire

// File: eth_loop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eth_loop_tb;

    localparam int unsigned FRAME_WORDS = eth_loop_pkg::DEF_FRAME_WORDS;
    localparam int unsigned GAP_CYCLES  = eth_loop_pkg::DEF_GAP_CYCLES;
    localparam int unsigned PIPE_LEN    = eth_loop_pkg::DEF_PIPE_LEN;
    // Last cycle at which a count may still move once the enable is cleared
    localparam int unsigned STOP_CYCLES = FRAME_WORDS + GAP_CYCLES + PIPE_LEN + 1;
    // Reset wait plus the budget of each of the six tests
    localparam int unsigned TEST_CYCLES = 60 + 200 + 200 + 2000 + 300 + 300 + 300;
    localparam int unsigned TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                     i_eth_clk = 1'b0;
    logic                     resetn = 1'b0;
    logic [2:0]               i_pll_lock = 3'b111;
    logic                     i_do_reset = 1'b0;
    logic                     i_stimuli_valid = 1'b0;
    logic [1:0]               i_tx_enable = 2'b00;
    logic [1:0]               i_tx_id = 2'b00;
    logic [1:0]               i_rx_stall = 2'b00;
    eth_loop_pkg::eth_led_t   o_led;
    eth_loop_pkg::eth_count_t o_frame_count0;
    eth_loop_pkg::eth_count_t o_frame_count1;
    logic [1:0]               o_error;

    logic [31:0]              lfsr_state = 32'h0000_c340;
    int unsigned              cycle_count = 0;
    int unsigned              error_count = 0;
    int unsigned              check_count = 0;
    int unsigned              test_count = 0;
    int unsigned              test_errors = 0;
    logic                     monitor_on = 1'b0;
    logic                     reset_expected = 1'b0;
    logic                     idle_bad = 1'b0;
    logic [1:0]               model_id = 2'b00;
    logic [1:0]               new_id;
    eth_loop_pkg::eth_count_t prev_count [2];
    eth_loop_pkg::eth_led_t   model_led [2];
    eth_loop_pkg::eth_count_t mark0;
    eth_loop_pkg::eth_count_t mark1;

    eth_loop_top uut (
        .i_eth_clk(i_eth_clk), .resetn(resetn), .i_pll_lock(i_pll_lock),
        .i_do_reset(i_do_reset), .i_stimuli_valid(i_stimuli_valid),
        .i_tx_enable(i_tx_enable), .i_tx_id(i_tx_id), .i_rx_stall(i_rx_stall),
        .o_led(o_led), .o_frame_count0(o_frame_count0), .o_frame_count1(o_frame_count1),
        .o_error(o_error)
    );

    always #20 i_eth_clk = ~i_eth_clk;

    // Hard stop in case a wait below never sees its frames
    always @(posedge i_eth_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ----------------------------------------
    // Random bits, model and compare
    // ----------------------------------------

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step for every bit handed out
    function automatic logic rand_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    // Sequence numbers start at 0, so frame number cnt carries sequence cnt-1
    // An ID of 1 inverts the LED byte
    function automatic eth_loop_pkg::eth_led_t led_for(input eth_loop_pkg::eth_count_t cnt,
                                                       input logic id);
        eth_loop_pkg::eth_led_t seq_low;
        seq_low = 8'(cnt - 1);
        return id ? ~seq_low : seq_low;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // A count may only step by one, except when a reset pulse drops it to 0
    task automatic track_channel(input int ch, input string name,
                                 input eth_loop_pkg::eth_count_t cnt, output logic moved);
        moved = (cnt != prev_count[ch]);
        if (moved) begin
            if (reset_expected && (cnt == 0)) begin
                model_led[ch] = 8'h00;
            end else begin
                check_value(name, cnt, prev_count[ch] + 1);
                model_led[ch] = led_for(cnt, model_id[ch]);
            end
            prev_count[ch] = cnt;
        end
    endtask

    // Outputs are looked at on the falling edge, well away from the DUT's updates
    always @(negedge i_eth_clk) begin
        logic moved0;
        logic moved1;
        if (monitor_on) begin
            track_channel(0, "o_frame_count0", o_frame_count0, moved0);
            track_channel(1, "o_frame_count1", o_frame_count1, moved1);
            if (moved0 || moved1) begin
                check_value("o_led", 32'(o_led), 32'(model_led[0] ^ model_led[1]));
                check_value("o_error", 32'(o_error), 32'd0);
            end
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // New settings only count once the strobe has taken them
    task automatic strobe_control(input logic [1:0] enable, input logic [1:0] id);
        @(posedge i_eth_clk);
        i_tx_enable     <= enable;
        i_tx_id         <= id;
        i_stimuli_valid <= 1'b1;
        model_id         = id;
        @(posedge i_eth_clk);
        i_stimuli_valid <= 1'b0;
    endtask

    // Roughly three cycles in four stall each receiver, enough to fill the link
    task automatic drive_random_stall();
        logic [1:0] stall;
        stall[0] = rand_bit() | rand_bit();
        stall[1] = rand_bit() | rand_bit();
        @(posedge i_eth_clk);
        i_rx_stall <= stall;
    endtask

    task automatic wait_cycles(input int unsigned n);
        repeat (n) @(posedge i_eth_clk);
    endtask

    task automatic wait_for_counts(input eth_loop_pkg::eth_count_t n0,
                                   input eth_loop_pkg::eth_count_t n1);
        @(negedge i_eth_clk);
        while ((o_frame_count0 < n0) || (o_frame_count1 < n1)) begin
            @(negedge i_eth_clk);
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_errors) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        // Power-up pipe and synchroniser release the DUT some 36 cycles in
        wait_cycles(10);
        resetn <= 1'b1;
        wait_cycles(50);
        @(negedge i_eth_clk);
        prev_count[0] = o_frame_count0;
        prev_count[1] = o_frame_count1;
        model_led[0]  = 8'h00;
        model_led[1]  = 8'h00;
        monitor_on    = 1'b1;

        // Nothing may move while both enables are still 0
        repeat (200) begin
            @(negedge i_eth_clk);
            if (!idle_bad && ({o_frame_count0, o_frame_count1, o_led, o_error} != '0)) begin
                idle_bad = 1'b1;
                check_value("o_frame_count0", o_frame_count0, 32'd0);
                check_value("o_frame_count1", o_frame_count1, 32'd0);
                check_value("o_led", 32'(o_led), 32'd0);
                check_value("o_error", 32'(o_error), 32'd0);
            end
        end
        end_test("idle after reset");

        // Channel 0 plain, channel 1 inverted
        strobe_control(2'b11, 2'b10);
        wait_for_counts(3, 3);
        @(negedge i_eth_clk);
        check_value("o_error", 32'(o_error), 32'd0);
        end_test("enable and LED rule");

        mark0 = o_frame_count0;
        mark1 = o_frame_count1;
        repeat (2000) drive_random_stall();
        @(posedge i_eth_clk);
        i_rx_stall <= 2'b00;
        @(negedge i_eth_clk);
        check_value("o_frame_count0 advanced", 32'(o_frame_count0 > mark0), 32'd1);
        check_value("o_frame_count1 advanced", 32'(o_frame_count1 > mark1), 32'd1);
        end_test("random back-pressure");

        // Frames in flight drain, then the counts must freeze
        strobe_control(2'b00, model_id);
        wait_cycles(STOP_CYCLES);
        @(negedge i_eth_clk);
        mark0 = o_frame_count0;
        mark1 = o_frame_count1;
        wait_cycles(100);
        @(negedge i_eth_clk);
        check_value("o_frame_count0", o_frame_count0, mark0);
        check_value("o_frame_count1", o_frame_count1, mark1);
        strobe_control(2'b11, model_id);
        wait_for_counts(mark0 + 3, mark1 + 3);
        end_test("disable and resume");

        // Swap IDs while idle, then move the ID pins without a strobe
        strobe_control(2'b00, model_id);
        wait_cycles(STOP_CYCLES + 20);
        strobe_control(2'b00, ~model_id);
        strobe_control(2'b11, model_id);
        @(posedge i_eth_clk);
        i_tx_id <= ~model_id;
        @(negedge i_eth_clk);
        wait_for_counts(o_frame_count0 + 4, o_frame_count1 + 4);
        check_value("o_error", 32'(o_error), 32'd0);
        end_test("ID change");

        @(posedge i_eth_clk);
        reset_expected = 1'b1;
        i_do_reset    <= 1'b1;
        @(posedge i_eth_clk);
        i_do_reset    <= 1'b0;
        wait_cycles(10);
        @(negedge i_eth_clk);
        check_value("o_frame_count0", o_frame_count0, 32'd0);
        check_value("o_frame_count1", o_frame_count1, 32'd0);
        check_value("o_led", 32'(o_led), 32'd0);
        check_value("o_error", 32'(o_error), 32'd0);
        reset_expected = 1'b0;
        // Capture block came out of reset with enable 0, so a strobe restarts the senders
        new_id[0] = rand_bit();
        new_id[1] = rand_bit();
        strobe_control(2'b11, new_id);
        wait_for_counts(3, 3);
        @(negedge i_eth_clk);
        check_value("o_error", 32'(o_error), 32'd0);
        end_test("reset request");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: eth_loop_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_loop_top #(
    parameter int unsigned             FRAME_WORDS = eth_loop_pkg::DEF_FRAME_WORDS,
    parameter int unsigned             GAP_CYCLES  = eth_loop_pkg::DEF_GAP_CYCLES,
    parameter int unsigned             LINK_DEPTH  = eth_loop_pkg::DEF_LINK_DEPTH,
    parameter eth_loop_pkg::eth_addr_t DEST_ADDR   = eth_loop_pkg::DEF_DEST_ADDR,
    parameter int unsigned             PIPE_LEN    = eth_loop_pkg::DEF_PIPE_LEN
) (
    input  wire                      i_eth_clk,
    input  wire                      resetn,
    input  wire [2:0]                i_pll_lock,
    input  wire                      i_do_reset,
    input  wire                      i_stimuli_valid,
    input  wire [1:0]                i_tx_enable,
    input  wire [1:0]                i_tx_id,
    input  wire [1:0]                i_rx_stall,
    output eth_loop_pkg::eth_led_t   o_led,
    output eth_loop_pkg::eth_count_t o_frame_count0,
    output eth_loop_pkg::eth_count_t o_frame_count1,
    output logic [1:0]               o_error
);

    // Capture block first, then sender, link and receiver for each channel
    localparam int unsigned NUM_RESETS = 7;

    logic [NUM_RESETS-1:0]    rstn;
    logic [1:0]               tx_enable;
    logic [1:0]               tx_id;
    eth_loop_pkg::eth_count_t frame_count [2];
    eth_loop_pkg::eth_led_t   led [2];

    eth_reset_seq #(.NUM_RESETS(NUM_RESETS)) u_reset_seq (
        .i_eth_clk(i_eth_clk), .resetn(resetn), .i_pll_lock(i_pll_lock),
        .i_do_reset(i_do_reset), .o_rstn(rstn)
    );

    eth_ctrl_capture #(.PIPE_LEN(PIPE_LEN)) u_ctrl_capture (
        .i_eth_clk(i_eth_clk), .resetn(rstn[0]), .i_stimuli_valid(i_stimuli_valid),
        .i_tx_enable(i_tx_enable), .i_tx_id(i_tx_id),
        .o_tx_enable(tx_enable), .o_tx_id(tx_id)
    );

    // ----------------------------------------
    // Sender, link and receiver per channel
    // ----------------------------------------
    for (genvar ch = 0; ch < 2; ch++) begin : g_chan
        logic tx_valid, tx_sop, tx_eop, credit, rx_valid, rx_sop, rx_eop, rx_ready;
        eth_loop_pkg::eth_data_t tx_data, rx_data;
        eth_loop_pkg::eth_addr_t tx_addr, rx_addr;

        eth_frame_sender #(.FRAME_WORDS(FRAME_WORDS), .GAP_CYCLES(GAP_CYCLES),
            .LINK_DEPTH(LINK_DEPTH), .DEST_ADDR(DEST_ADDR)) u_sender (
            .i_eth_clk(i_eth_clk), .resetn(rstn[1+3*ch]), .i_enable(tx_enable[ch]),
            .i_id(tx_id[ch]), .i_credit(credit), .o_valid(tx_valid), .o_data(tx_data),
            .o_sop(tx_sop), .o_eop(tx_eop), .o_addr(tx_addr)
        );

        // Buffer in place of the network access point
        eth_credit_link #(.LINK_DEPTH(LINK_DEPTH)) u_link (
            .i_eth_clk(i_eth_clk), .resetn(rstn[2+3*ch]), .i_valid(tx_valid),
            .i_data(tx_data), .i_sop(tx_sop), .i_eop(tx_eop), .i_addr(tx_addr),
            .i_ready(rx_ready), .o_valid(rx_valid), .o_data(rx_data), .o_sop(rx_sop),
            .o_eop(rx_eop), .o_addr(rx_addr), .o_credit(credit)
        );

        eth_frame_receiver #(.MY_ADDR(DEST_ADDR)) u_receiver (
            .i_eth_clk(i_eth_clk), .resetn(rstn[3+3*ch]), .i_valid(rx_valid),
            .i_data(rx_data), .i_sop(rx_sop), .i_eop(rx_eop), .i_addr(rx_addr),
            .i_stall(i_rx_stall[ch]), .o_ready(rx_ready), .o_frame_count(frame_count[ch]),
            .o_led(led[ch]), .o_error(o_error[ch])
        );
    end

    // LEDs show both channels mixed together
    assign o_led          = led[0] ^ led[1];
    assign o_frame_count0 = frame_count[0];
    assign o_frame_count1 = frame_count[1];

endmodule

`default_nettype wire

// File: eth_reset_seq.sv
`timescale 1ns/1ps
`default_nettype none

module eth_reset_seq #(
    parameter int unsigned NUM_RESETS = 7
) (
    input  wire                    i_eth_clk,
    input  wire                    resetn,
    input  wire [2:0]              i_pll_lock,
    input  wire                    i_do_reset,
    output logic [NUM_RESETS-1:0]  o_rstn
);

    localparam int unsigned POWER_PIPE_LEN = 32;

    // Board has no reset pin, so a pipe of ones fills up after power-up
    // The initial value is what holds the design in reset at start
    logic [POWER_PIPE_LEN-1:0] power_pipe = '0;
    logic [2:0]                sync_pipe;
    logic                      src_ok;

    always_ff @(posedge i_eth_clk) begin
        power_pipe <= {power_pipe[POWER_PIPE_LEN-2:0], 1'b1};
    end

    // Every source must be high for the design to leave reset
    assign src_ok = resetn & (&i_pll_lock) & ~i_do_reset & power_pipe[POWER_PIPE_LEN-1];

    // Three stage synchroniser for the release edge
    // A low source clears it at once, so assertion takes effect on the next edge
    always_ff @(posedge i_eth_clk) begin
        if (!src_ok) begin
            sync_pipe <= '0;
        end else begin
            sync_pipe <= {sync_pipe[1:0], 1'b1};
        end
    end

    // One register per destination block, so each reset can be placed near its user
    // Release lands four edges after all sources are high
    always_ff @(posedge i_eth_clk) begin
        if (!src_ok) begin
            o_rstn <= '0;
        end else begin
            o_rstn <= {NUM_RESETS{sync_pipe[2]}};
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module eth_loop_tb \
    -f eth_loop.f -o eth_loop_sim

./obj_dir/eth_loop_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
